// ==== rtl/ram_pkg.sv ====
/*
 * RAM geometry package
 * Shared widths and vector types for the byte-column dual-port memory
 * and the 33-bit user word that the wrapper presents on each port.
 */
`default_nettype none

package ram_pkg;

    // Word address into the array
    localparam int addr_w = 12;
    // One column is a byte plus its parity bit
    localparam int col_w = 9;
    localparam int nb_col = 4;
    // A full memory word is made of all columns side by side
    localparam int word_w = nb_col * col_w;
    // User data only fills the low part of a memory word
    localparam int user_w = 33;
    localparam int ram_depth = 2 ** addr_w;

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [word_w-1:0] word_t;
    typedef logic [user_w-1:0] user_t;
    // One write enable per column, bit c covers word bits [c*col_w +: col_w]
    typedef logic [nb_col-1:0] col_en_t;

endpackage

`default_nettype wire

// ==== rtl/dpram_core.sv ====
/*
 * Byte-column true dual-port block RAM model
 * Both ports read first and write any subset of the 9-bit columns.
 * Port A wins when both ports write one column in the same cycle.
 * Each port reads through a latch and an output register, so read data
 * appears two edges after the address is sampled.
 */
`timescale 1ns/1ps
`default_nettype none

module dpram_core #(
    parameter int ram_depth_p = ram_pkg::ram_depth
) (
    input  wire logic            ram_inf,
    input  wire logic            rst_n,
    input  wire ram_pkg::addr_t  addra,
    input  wire ram_pkg::addr_t  addrb,
    input  wire ram_pkg::word_t  dina,
    input  wire ram_pkg::word_t  dinb,
    input  wire ram_pkg::col_en_t wea,
    input  wire ram_pkg::col_en_t web,
    input  wire logic            rsta,
    input  wire logic            rstb,
    output ram_pkg::word_t       douta,
    output ram_pkg::word_t       doutb
);

    import ram_pkg::*;

    // Index width for the configured depth, smaller arrays drop the upper address bits
    localparam int idx_w = $clog2(ram_depth_p);

    // The array starts cleared, the same way a block RAM without an init file powers up
    word_t mem [ram_depth_p] = '{default: '0};

    // First read stage of each port
    word_t ram_data_a;
    word_t ram_data_b;

    logic [idx_w-1:0] idx_a;
    logic [idx_w-1:0] idx_b;

    assign idx_a = addra[idx_w-1:0];
    assign idx_b = addrb[idx_w-1:0];

    // Array access for both ports on the shared clock
    always_ff @(posedge ram_inf) begin
        // The latches sample the word before this edge's writes land,
        // which gives read-first behavior on both ports
        ram_data_a <= mem[idx_a];
        ram_data_b <= mem[idx_b];

        // Port B is scheduled first
        for (int c = 0; c < nb_col; c++) begin
            if (web[c]) begin
                mem[idx_b][c*col_w +: col_w] <= dinb[c*col_w +: col_w];
            end
        end

        // Port A is scheduled last, so its column overrides B on a shared address
        for (int c = 0; c < nb_col; c++) begin
            if (wea[c]) begin
                mem[idx_a][c*col_w +: col_w] <= dina[c*col_w +: col_w];
            end
        end
    end

    // Port A output register
    // rsta clears it at the next edge, the latch behind it keeps running
    always_ff @(posedge ram_inf or negedge rst_n) begin
        if (!rst_n) begin
            douta <= '0;
        end else if (rsta) begin
            douta <= '0;
        end else begin
            douta <= ram_data_a;
        end
    end

    // Port B output register, same behavior with rstb
    always_ff @(posedge ram_inf or negedge rst_n) begin
        if (!rst_n) begin
            doutb <= '0;
        end else if (rstb) begin
            doutb <= '0;
        end else begin
            doutb <= ram_data_b;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/common_ram_wrapper.sv ====
/*
 * Common RAM wrapper
 * Presents the 36-bit column memory as a 33-bit word per port.
 * One write strobe per port drives every column, and each port's
 * read data gets one more register stage, for three edges in total.
 */
`timescale 1ns/1ps
`default_nettype none

module common_ram_wrapper (
    input  wire logic           ram_inf,
    input  wire logic           rst_n,
    input  wire ram_pkg::addr_t addra,
    input  wire ram_pkg::addr_t addrb,
    input  wire ram_pkg::user_t dia,
    input  wire ram_pkg::user_t dib,
    input  wire logic           wea,
    input  wire logic           web,
    input  wire logic           rsta,
    input  wire logic           rstb,
    output ram_pkg::user_t      doa,
    output ram_pkg::user_t      dob
);

    import ram_pkg::*;

    word_t   dina;
    word_t   dinb;
    word_t   douta;
    word_t   doutb;
    col_en_t wea_col;
    col_en_t web_col;

    // The spare upper bits of every stored word are written as zero
    assign dina = {{(word_w - user_w){1'b0}}, dia};
    assign dinb = {{(word_w - user_w){1'b0}}, dib};

    // A user write always covers the whole word
    assign wea_col = {nb_col{wea}};
    assign web_col = {nb_col{web}};

    dpram_core #(
        .ram_depth_p (ram_depth)
    ) dpram_core_i (
        .ram_inf (ram_inf),
        .rst_n   (rst_n),
        .addra   (addra),
        .addrb   (addrb),
        .dina    (dina),
        .dinb    (dinb),
        .wea     (wea_col),
        .web     (web_col),
        .rsta    (rsta),
        .rstb    (rstb),
        .douta   (douta),
        .doutb   (doutb)
    );

    // Third read stage, only the user part of the word is kept
    always_ff @(posedge ram_inf or negedge rst_n) begin
        if (!rst_n) begin
            doa <= '0;
            dob <= '0;
        end else begin
            doa <= douta[user_w-1:0];
            dob <= doutb[user_w-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/write_collision_detect.sv ====
/*
 * Write collision detector
 * Raises a one-cycle pulse after an edge on which both ports wrote
 * the same address. Hardware leaves such a word undefined, while the
 * memory model here keeps port A's data.
 */
`timescale 1ns/1ps
`default_nettype none

module write_collision_detect (
    input  wire logic           ram_inf,
    input  wire logic           rst_n,
    input  wire logic           wea,
    input  wire logic           web,
    input  wire ram_pkg::addr_t addra,
    input  wire ram_pkg::addr_t addrb,
    output logic                collision
);

    logic same_addr;
    logic both_write;

    // Compare the full address, both ports see the same array
    assign same_addr = (addra == addrb);
    assign both_write = wea & web;

    // The flag is rebuilt on every edge, so it lasts one cycle
    // unless the cause repeats on the next edge
    always_ff @(posedge ram_inf or negedge rst_n) begin
        if (!rst_n) begin
            collision <= 1'b0;
        end else begin
            collision <= both_write & same_addr;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ram_subsystem.sv ====
/*
 * RAM subsystem top level
 * Dual-port 4096 x 33-bit memory with read data three edges after
 * the address, plus a flag for same-address writes on both ports.
 */
`timescale 1ns/1ps
`default_nettype none

module ram_subsystem (
    input  wire logic           ram_inf,
    input  wire logic           rst_n,
    input  wire ram_pkg::addr_t addra,
    input  wire ram_pkg::user_t dia,
    input  wire logic           wea,
    input  wire logic           rsta,
    input  wire ram_pkg::addr_t addrb,
    input  wire ram_pkg::user_t dib,
    input  wire logic           web,
    input  wire logic           rstb,
    output ram_pkg::user_t      doa,
    output ram_pkg::user_t      dob,
    output logic                collision
);

    // Memory path for both ports
    common_ram_wrapper common_ram_wrapper_i (
        .ram_inf (ram_inf),
        .rst_n   (rst_n),
        .addra   (addra),
        .addrb   (addrb),
        .dia     (dia),
        .dib     (dib),
        .wea     (wea),
        .web     (web),
        .rsta    (rsta),
        .rstb    (rstb),
        .doa     (doa),
        .dob     (dob)
    );

    // Watches the same strobes and addresses that reach the array
    write_collision_detect write_collision_detect_i (
        .ram_inf   (ram_inf),
        .rst_n     (rst_n),
        .wea       (wea),
        .web       (web),
        .addra     (addra),
        .addrb     (addrb),
        .collision (collision)
    );

endmodule

`default_nettype wire

// ==== bench/ram_subsystem_props.sv ====
/*
 * RAM subsystem properties
 * Bound to the top level, covers the collision pulse and the
 * reset values of the outputs.
 */
`timescale 1ns/1ps
`default_nettype none

module ram_subsystem_props (
    input wire logic           ram_inf,
    input wire logic           rst_n,
    input wire logic           wea,
    input wire logic           web,
    input wire ram_pkg::addr_t addra,
    input wire ram_pkg::addr_t addrb,
    input wire ram_pkg::user_t doa,
    input wire ram_pkg::user_t dob,
    input wire logic           collision
);

    // Every pulse needs a same-address write on both ports one edge earlier
    collision_has_cause: assert property (
        @(posedge ram_inf) disable iff (!rst_n)
        collision |-> $past(wea && web && (addra == addrb))
    ) else $error("collision without a same-address write on both ports");

    // Each such write raises the flag on the next edge, so with the check above
    // the flag is high for exactly the cycles that follow a cause
    collision_follows_cause: assert property (
        @(posedge ram_inf) disable iff (!rst_n)
        (wea && web && (addra == addrb)) |=> collision
    ) else $error("same-address write on both ports without a collision pulse");

    // All outputs sit at zero while reset is held
    outputs_clear_in_reset: assert property (
        @(posedge ram_inf)
        !rst_n |-> (doa == '0 && dob == '0 && !collision)
    ) else $error("outputs not zero during reset");

endmodule

`default_nettype wire

// ==== bench/ram_subsystem_tb.sv ====
/*
 * Testbench for the RAM subsystem
 * Applies a table of per-port operations one entry per cycle and checks
 * both read ports and the collision flag against a reference model
 * that keeps 33-bit words, reads first and lets port A win.
 */
`timescale 1ns/1ps
`default_nettype none

module ram_subsystem_tb;

    import ram_pkg::*;

    localparam int rst_cycles = 16;
    localparam int n_random = 40;
    // Spare cycles on top of reset and table before the run counts as hung
    localparam int margin_cycles = 50;

    // Operation of one port in a table entry
    localparam logic [1:0] op_idle = 2'd0;
    localparam logic [1:0] op_read = 2'd1;
    localparam logic [1:0] op_write = 2'd2;

    typedef struct packed {
        logic [1:0] op_a;
        addr_t      addr_a;
        user_t      data_a;
        logic       rst_a;
        logic [1:0] op_b;
        addr_t      addr_b;
        user_t      data_b;
        logic       rst_b;
    } entry_t;

    logic  ram_inf;
    logic  rst_n;
    addr_t addra;
    user_t dia;
    logic  wea;
    logic  rsta;
    addr_t addrb;
    user_t dib;
    logic  web;
    logic  rstb;
    user_t doa;
    user_t dob;
    logic  collision;

    entry_t tbl[$];
    // Words never written read as zero, like the cleared array
    user_t  ref_mem [addr_t];
    // Expected port outputs where stage 2 is due at the current check
    user_t  exp_a [3];
    user_t  exp_b [3];
    logic   exp_coll;
    integer seed;
    int     cycle_count;
    int     cycle_limit = 0;

    ram_subsystem ram_subsystem_i (
        .ram_inf   (ram_inf),
        .rst_n     (rst_n),
        .addra     (addra),
        .dia       (dia),
        .wea       (wea),
        .rsta      (rsta),
        .addrb     (addrb),
        .dib       (dib),
        .web       (web),
        .rstb      (rstb),
        .doa       (doa),
        .dob       (dob),
        .collision (collision)
    );

    bind ram_subsystem ram_subsystem_props ram_subsystem_props_i (
        .ram_inf   (ram_inf),
        .rst_n     (rst_n),
        .wea       (wea),
        .web       (web),
        .addra     (addra),
        .addrb     (addrb),
        .doa       (doa),
        .dob       (dob),
        .collision (collision)
    );

    always #4 ram_inf = ~ram_inf;

    // Ends a run that never reaches the end of the table
    always @(posedge ram_inf) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            abort_run($sformatf("Timeout after %0d cycles, table not finished", cycle_count));
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input user_t got, input user_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic user_t read_model(input addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : '0;
    endfunction

    function automatic user_t rand_data();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[user_w-1:0];
    endfunction

    task automatic add_entry(input logic [1:0] op_a, input addr_t addr_a, input user_t data_a,
                             input logic [1:0] op_b, input addr_t addr_b, input user_t data_b,
                             input logic rst_a = 1'b0, input logic rst_b = 1'b0);
        tbl.push_back('{op_a, addr_a, data_a, rst_a, op_b, addr_b, data_b, rst_b});
    endtask

    task automatic build_table();
        logic [31:0] ra;
        logic [31:0] rb;
        user_t       da;
        user_t       db;
        // Every output must still read zero in the quiet cycles after reset
        repeat (4) add_entry(op_idle, '0, '0, op_idle, '0, '0);
        // One write per port, then both ports read each word back
        add_entry(op_write, 12'h010, 33'h1_2345_6789, op_write, 12'h020, 33'h0_dead_beef);
        add_entry(op_read, 12'h010, '0, op_read, 12'h010, '0);
        add_entry(op_read, 12'h020, '0, op_read, 12'h020, '0);
        // Fill two areas, then stream reads with three results in flight
        for (int j = 0; j < 6; j++) begin
            da = rand_data();
            db = rand_data();
            add_entry(op_write, addr_t'(12'h100 + j), da, op_write, addr_t'(12'h180 + j), db);
        end
        for (int j = 0; j < 6; j++) begin
            add_entry(op_read, addr_t'(12'h100 + j), '0, op_read, addr_t'(12'h185 - j), '0);
        end
        // A write and a read of one word on the same edge see the old value
        da = rand_data();
        db = rand_data();
        add_entry(op_write, 12'h100, da, op_read, 12'h100, '0);
        add_entry(op_read, 12'h181, '0, op_write, 12'h181, db);
        add_entry(op_read, 12'h181, '0, op_read, 12'h100, '0);
        // Same address on both ports, A's data stays and the flag pulses once
        add_entry(op_write, 12'h300, 33'h1_aaaa_5555, op_write, 12'h300, 33'h0_5555_aaaa);
        add_entry(op_idle, '0, '0, op_idle, '0, '0);
        add_entry(op_read, 12'h300, '0, op_read, 12'h300, '0);
        // Different addresses on the same edge raise no flag
        add_entry(op_write, 12'h301, 33'h0_0000_0301, op_write, 12'h302, 33'h1_0000_0302);
        add_entry(op_read, 12'h302, '0, op_read, 12'h301, '0);
        // Output clear on port A in the middle of a read stream
        for (int j = 0; j < 6; j++) begin
            add_entry(op_read, addr_t'(12'h100 + j), '0, op_read, addr_t'(12'h180 + j), '0,
                      j == 3);
        end
        // Random traffic in a small window so that collisions and rereads occur
        for (int j = 0; j < n_random; j++) begin
            ra = $random(seed);
            rb = $random(seed);
            da = rand_data();
            db = rand_data();
            add_entry(2'(ra[31:16] % 16'd3), {9'h07e, ra[2:0]}, da,
                      2'(rb[31:16] % 16'd3), {9'h07e, rb[2:0]}, db);
        end
        // Drain the read pipeline
        repeat (4) add_entry(op_idle, '0, '0, op_idle, '0, '0);
    endtask

    // Each table entry is driven on the rising edge and checked on the falling edge
    task automatic apply_entry(input entry_t e);
        user_t rd_a;
        user_t rd_b;
        logic  coll_now;
        @(posedge ram_inf);
        addra <= e.addr_a;
        dia <= e.data_a;
        wea <= (e.op_a == op_write);
        rsta <= e.rst_a;
        addrb <= e.addr_b;
        dib <= e.data_b;
        web <= (e.op_b == op_write);
        rstb <= e.rst_b;
        // The array is read on every edge, idle or not, and before the writes land
        rd_a = read_model(e.addr_a);
        rd_b = read_model(e.addr_b);
        if (e.op_b == op_write) begin
            ref_mem[e.addr_b] = e.data_b;
        end
        if (e.op_a == op_write) begin
            ref_mem[e.addr_a] = e.data_a;
        end
        coll_now = (e.op_a == op_write) && (e.op_b == op_write) && (e.addr_a == e.addr_b);
        @(negedge ram_inf);
        check_value("doa", doa, exp_a[2]);
        check_value("dob", dob, exp_b[2]);
        check_value("collision", user_t'(collision), user_t'(exp_coll));
        exp_a[2] = exp_a[1];
        exp_a[1] = exp_a[0];
        exp_a[0] = rd_a;
        exp_b[2] = exp_b[1];
        exp_b[1] = exp_b[0];
        exp_b[0] = rd_b;
        // A clear hits the output register, which holds the previous entry's read
        if (e.rst_a) begin
            exp_a[1] = '0;
        end
        if (e.rst_b) begin
            exp_b[1] = '0;
        end
        exp_coll = coll_now;
    endtask

    initial begin
        seed = 32'h796e6f06;
        cycle_count = 0;
        ram_inf = 1'b0;
        rst_n = 1'b0;
        addra = '0;
        dia = '0;
        wea = 1'b0;
        rsta = 1'b0;
        addrb = '0;
        dib = '0;
        web = 1'b0;
        rstb = 1'b0;
        // Outputs come out of reset as zero
        for (int k = 0; k < 3; k++) begin
            exp_a[k] = '0;
            exp_b[k] = '0;
        end
        exp_coll = 1'b0;
        build_table();
        cycle_limit = rst_cycles + tbl.size() + margin_cycles;
        repeat (rst_cycles) @(posedge ram_inf);
        rst_n <= 1'b1;
        foreach (tbl[i]) begin
            apply_entry(tbl[i]);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== ram_subsystem.f ====
rtl/ram_pkg.sv
rtl/dpram_core.sv
rtl/common_ram_wrapper.sv
rtl/write_collision_detect.sv
rtl/ram_subsystem.sv
bench/ram_subsystem_props.sv
bench/ram_subsystem_tb.sv

// ==== Makefile ====
# Verilator flow for the dual-port RAM subsystem

TOP := ram_subsystem_tb
BUILD := build

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f ram_subsystem.f --top-module $(TOP)

# The run passes only when the pass line shows up in the output
sim:
	verilator --binary --timing --assert -f ram_subsystem.f --top-module $(TOP) \
		-Mdir $(BUILD) -o $(TOP)
	@out=$$(./$(BUILD)/$(TOP)); echo "$$out"; \
		echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(BUILD)
